//--- common/mchan_defines.svh
// ****************************************
// DMA controller widths and sizes
// Control register byte offsets
// ****************************************

`ifndef MCHAN_DEFINES_SVH
`define MCHAN_DEFINES_SVH

// Data word and address widths
`define MCHAN_DATA_WIDTH 32
`define MCHAN_ADDR_WIDTH 32

// Transfer length in words
`define MCHAN_LEN_WIDTH 16

// Commands held per control port
`define MCHAN_QUEUE_DEPTH 2

// Register map, decoded on the low address nibble
`define MCHAN_REG_CMD       4'h0
`define MCHAN_REG_TCDM_ADDR 4'h4
`define MCHAN_REG_EXT_ADDR  4'h8

`endif

//--- common/mchan_pkg.sv
// ****************************************
// DMA controller package
// Command register word, command and status views
// ****************************************

`default_nettype none

`include "mchan_defines.svh"

package mchan_pkg;

  // Command register word
  // Written it is a command, read back it is the port status
  typedef union packed {
    struct packed {
      logic [`MCHAN_DATA_WIDTH-`MCHAN_LEN_WIDTH-2:0] spare;
      // 0 copies external to TCDM, 1 copies TCDM to external
      logic                                          dir;
      // Length in words
      logic [`MCHAN_LEN_WIDTH-1:0]                   len;
    } cmd;
    struct packed {
      logic [`MCHAN_DATA_WIDTH-17:0] spare_hi;
      // Completed commands, wraps
      logic [7:0]                    done_cnt;
      logic [3:0]                    spare_lo;
      // Commands still queued
      logic [2:0]                    pending;
      logic                          busy;
    } status;
  } mchan_cmd_word_u;

endpackage

`default_nettype wire

//--- common/mchan_cmd_if.sv
// ****************************************
// Command link from a control unit
// to the transfer unit, with done pulse
// ****************************************

`default_nettype none

`include "mchan_defines.svh"

interface mchan_cmd_if;

  // Head of queue handshake
  logic                         valid;
  logic                         ready;

  // Command payload, stable while valid
  logic                         dir;
  logic [`MCHAN_LEN_WIDTH-1:0]  len;
  logic [`MCHAN_ADDR_WIDTH-1:0] tcdm_addr;
  logic [`MCHAN_ADDR_WIDTH-1:0] ext_addr;

  // One cycle pulse when the command has finished
  logic                         done;

  modport ctrl (output valid, dir, len, tcdm_addr, ext_addr, input ready, done);
  modport xfer (input valid, dir, len, tcdm_addr, ext_addr, output ready, done);

endinterface

`default_nettype wire

//--- mchan/mchan_ctrl_unit.sv
// ****************************************
// DMA control unit
// Wishbone registers, command queue,
// completion counter and termination event
// ****************************************

`default_nettype none

`include "mchan_defines.svh"

module mchan_ctrl_unit (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         wb_we_i,
  input  logic [`MCHAN_ADDR_WIDTH-1:0] wb_adr_i,
  input  logic [`MCHAN_DATA_WIDTH-1:0] wb_dat_i,
  input  logic [3:0]                   wb_sel_i,
  output logic [`MCHAN_DATA_WIDTH-1:0] wb_dat_o,
  output logic                         wb_ack_o,
  output logic                         term_evt_o,
  output logic                         pending_o,
  mchan_cmd_if.ctrl                    cmd
);

  import mchan_pkg::*;

  localparam int DEPTH = `MCHAN_QUEUE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic                         new_req;
  logic                         sel_cmd;
  logic                         sel_tcdm;
  logic                         sel_ext;
  logic                         cmd_wr;
  logic                         q_full;
  logic                         push;
  logic                         pop;
  logic                         accept;
  logic [`MCHAN_DATA_WIDTH-1:0] rd_data;
  mchan_cmd_word_u              wr_word;
  mchan_cmd_word_u              status_word;

  // Staged transfer addresses
  logic [`MCHAN_ADDR_WIDTH-1:0] tcdm_addr_q;
  logic [`MCHAN_ADDR_WIDTH-1:0] ext_addr_q;

  // Command queue storage
  logic                         q_dir  [DEPTH];
  logic [`MCHAN_LEN_WIDTH-1:0]  q_len  [DEPTH];
  logic [`MCHAN_ADDR_WIDTH-1:0] q_tcdm [DEPTH];
  logic [`MCHAN_ADDR_WIDTH-1:0] q_ext  [DEPTH];
  logic [PTR_W-1:0]             wr_ptr_q;
  logic [PTR_W-1:0]             rd_ptr_q;
  logic [CNT_W-1:0]             q_cnt_q;

  // Popped but not yet done
  logic                         inflight_q;
  logic [7:0]                   done_cnt_q;

  // ****************************************
  // Wishbone decode
  // ****************************************

  // New request only when no ack is pending
  assign new_req  = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign sel_cmd  = wb_adr_i[3:0] == `MCHAN_REG_CMD;
  assign sel_tcdm = wb_adr_i[3:0] == `MCHAN_REG_TCDM_ADDR;
  assign sel_ext  = wb_adr_i[3:0] == `MCHAN_REG_EXT_ADDR;
  assign cmd_wr   = new_req & wb_we_i & sel_cmd;
  assign q_full   = q_cnt_q == CNT_W'(DEPTH);

  // Command write stalls while the queue is full
  assign push   = cmd_wr & ~q_full;
  assign accept = new_req & ~(cmd_wr & q_full);
  assign pop    = cmd.valid & cmd.ready;

  assign wr_word = wb_dat_i;

  // Status view of the command word
  always_comb begin
    status_word                 = '0;
    status_word.status.busy     = pending_o | inflight_q;
    status_word.status.pending  = 3'(q_cnt_q);
    status_word.status.done_cnt = done_cnt_q;
    if (sel_cmd) begin
      rd_data = status_word;
    end else if (sel_tcdm) begin
      rd_data = tcdm_addr_q;
    end else if (sel_ext) begin
      rd_data = ext_addr_q;
    end else begin
      rd_data = '0;
    end
  end

  // Read data and address staging, byte lanes from sel
  always_ff @(posedge clk_i) begin
    if (accept & ~wb_we_i) begin
      wb_dat_o <= rd_data;
    end
    if (accept & wb_we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (wb_sel_i[b] & sel_tcdm) begin
          tcdm_addr_q[8*b +: 8] <= wb_dat_i[8*b +: 8];
        end
        if (wb_sel_i[b] & sel_ext) begin
          ext_addr_q[8*b +: 8] <= wb_dat_i[8*b +: 8];
        end
      end
    end
  end

  // ****************************************
  // Command queue
  // ****************************************

  // Entry takes the written length and direction plus staged addresses
  always_ff @(posedge clk_i) begin
    if (push) begin
      q_dir[wr_ptr_q]  <= wr_word.cmd.dir;
      q_len[wr_ptr_q]  <= wr_word.cmd.len;
      q_tcdm[wr_ptr_q] <= tcdm_addr_q;
      q_ext[wr_ptr_q]  <= ext_addr_q;
    end
  end

  // Head entry held until ready
  assign cmd.valid     = q_cnt_q != '0;
  assign cmd.dir       = q_dir[rd_ptr_q];
  assign cmd.len       = q_len[rd_ptr_q];
  assign cmd.tcdm_addr = q_tcdm[rd_ptr_q];
  assign cmd.ext_addr  = q_ext[rd_ptr_q];
  assign pending_o     = cmd.valid;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_ack_o   <= 1'b0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      q_cnt_q    <= '0;
      inflight_q <= 1'b0;
      done_cnt_q <= '0;
      term_evt_o <= 1'b0;
    end else begin
      wb_ack_o <= accept;
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   q_cnt_q <= q_cnt_q + 1'b1;
        2'b01:   q_cnt_q <= q_cnt_q - 1'b1;
        default: q_cnt_q <= q_cnt_q;
      endcase
      // Done always follows its pop by at least a cycle
      if (pop) begin
        inflight_q <= 1'b1;
      end else if (cmd.done) begin
        inflight_q <= 1'b0;
      end
      if (cmd.done) begin
        done_cnt_q <= done_cnt_q + 1'b1;
      end
      // Registered termination event
      term_evt_o <= cmd.done;
    end
  end

endmodule

`default_nettype wire

//--- mchan/mchan_xfer_unit.sv
// ****************************************
// DMA transfer unit
// Round robin over two command links,
// word copy between TCDM and external port
// ****************************************

`default_nettype none

`include "mchan_defines.svh"

module mchan_xfer_unit (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  mchan_cmd_if.xfer                      cl_cmd,
  mchan_cmd_if.xfer                      fc_cmd,
  // TCDM port
  output logic                           tcdm_req_o,
  output logic [`MCHAN_ADDR_WIDTH-1:0]   tcdm_add_o,
  output logic                           tcdm_wen_o,
  output logic [`MCHAN_DATA_WIDTH/8-1:0] tcdm_be_o,
  output logic [`MCHAN_DATA_WIDTH-1:0]   tcdm_wdata_o,
  input  logic                           tcdm_gnt_i,
  input  logic                           tcdm_r_valid_i,
  input  logic [`MCHAN_DATA_WIDTH-1:0]   tcdm_r_rdata_i,
  // External port
  output logic                           ext_req_o,
  output logic [`MCHAN_ADDR_WIDTH-1:0]   ext_add_o,
  output logic                           ext_wen_o,
  output logic [`MCHAN_DATA_WIDTH/8-1:0] ext_be_o,
  output logic [`MCHAN_DATA_WIDTH-1:0]   ext_wdata_o,
  input  logic                           ext_gnt_i,
  input  logic                           ext_r_valid_i,
  input  logic [`MCHAN_DATA_WIDTH-1:0]   ext_r_rdata_i,
  output logic                           active_o
);

  // FSM encoding
  localparam logic [2:0] S_IDLE    = 3'd0;
  localparam logic [2:0] S_RD_REQ  = 3'd1;
  localparam logic [2:0] S_RD_WAIT = 3'd2;
  localparam logic [2:0] S_WR_REQ  = 3'd3;
  localparam logic [2:0] S_DONE    = 3'd4;

  logic [2:0]                   state_q;
  // High when fc has priority for the next pick
  logic                         rr_q;
  // Owner of the running command
  logic                         src_fc_q;
  logic                         dir_q;
  logic [`MCHAN_LEN_WIDTH-1:0]  cnt_q;
  logic [`MCHAN_ADDR_WIDTH-1:0] tcdm_addr_q;
  logic [`MCHAN_ADDR_WIDTH-1:0] ext_addr_q;
  logic [`MCHAN_DATA_WIDTH-1:0] data_q;

  logic                         pick_cl;
  logic                         pick_fc;
  logic                         pick;
  logic                         new_dir;
  logic [`MCHAN_LEN_WIDTH-1:0]  new_len;
  logic                         rd_ph;
  logic                         wr_ph;
  logic                         src_gnt;
  logic                         src_rvalid;
  logic [`MCHAN_DATA_WIDTH-1:0] src_rdata;
  logic                         dst_gnt;

  // ****************************************
  // Arbitration
  // ****************************************

  // cl wins unless fc also waits and holds the turn
  assign pick_cl = (state_q == S_IDLE) & cl_cmd.valid & (~fc_cmd.valid | ~rr_q);
  assign pick_fc = (state_q == S_IDLE) & fc_cmd.valid & ~pick_cl;
  assign pick    = pick_cl | pick_fc;

  assign cl_cmd.ready = pick_cl;
  assign fc_cmd.ready = pick_fc;

  assign new_dir = pick_fc ? fc_cmd.dir : cl_cmd.dir;
  assign new_len = pick_fc ? fc_cmd.len : cl_cmd.len;

  // Done pulse goes back to the owner only
  assign cl_cmd.done = (state_q == S_DONE) & ~src_fc_q;
  assign fc_cmd.done = (state_q == S_DONE) & src_fc_q;

  // ****************************************
  // Memory ports
  // ****************************************

  assign rd_ph = state_q == S_RD_REQ;
  assign wr_ph = state_q == S_WR_REQ;

  // dir 0 reads external and writes TCDM, dir 1 the other way
  assign src_gnt    = dir_q ? tcdm_gnt_i : ext_gnt_i;
  assign src_rvalid = dir_q ? tcdm_r_valid_i : ext_r_valid_i;
  assign src_rdata  = dir_q ? tcdm_r_rdata_i : ext_r_rdata_i;
  assign dst_gnt    = dir_q ? ext_gnt_i : tcdm_gnt_i;

  assign tcdm_req_o   = (rd_ph & dir_q) | (wr_ph & ~dir_q);
  assign tcdm_add_o   = tcdm_addr_q;
  assign tcdm_wen_o   = ~wr_ph;
  assign tcdm_be_o    = '1;
  assign tcdm_wdata_o = data_q;

  assign ext_req_o   = (rd_ph & ~dir_q) | (wr_ph & dir_q);
  assign ext_add_o   = ext_addr_q;
  assign ext_wen_o   = ~wr_ph;
  assign ext_be_o    = '1;
  assign ext_wdata_o = data_q;

  assign active_o = state_q != S_IDLE;

  // ****************************************
  // Copy engine
  // ****************************************

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= S_IDLE;
      rr_q     <= 1'b0;
      src_fc_q <= 1'b0;
      dir_q    <= 1'b0;
      cnt_q    <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (pick) begin
            rr_q     <= pick_cl;
            src_fc_q <= pick_fc;
            dir_q    <= new_dir;
            cnt_q    <= new_len;
            // Zero length skips straight to done
            state_q  <= (new_len == '0) ? S_DONE : S_RD_REQ;
          end
        end
        S_RD_REQ: begin
          if (src_gnt) begin
            state_q <= S_RD_WAIT;
          end
        end
        S_RD_WAIT: begin
          if (src_rvalid) begin
            state_q <= S_WR_REQ;
          end
        end
        S_WR_REQ: begin
          if (dst_gnt) begin
            cnt_q   <= cnt_q - 1'b1;
            state_q <= (cnt_q == 1) ? S_DONE : S_RD_REQ;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Current addresses and word buffer
  always_ff @(posedge clk_i) begin
    if (pick) begin
      tcdm_addr_q <= pick_fc ? fc_cmd.tcdm_addr : cl_cmd.tcdm_addr;
      ext_addr_q  <= pick_fc ? fc_cmd.ext_addr : cl_cmd.ext_addr;
    end else if (wr_ph & dst_gnt) begin
      tcdm_addr_q <= tcdm_addr_q + 'd4;
      ext_addr_q  <= ext_addr_q + 'd4;
    end
    if ((state_q == S_RD_WAIT) & src_rvalid) begin
      data_q <= src_rdata;
    end
  end

endmodule

`default_nettype wire

//--- design/dmac_wrap.sv
// ****************************************
// DMA controller top level
// cl and fc control units, transfer unit
// ****************************************

`default_nettype none

`include "mchan_defines.svh"

module dmac_wrap (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  // Cluster control port
  input  logic                           cl_wb_cyc_i,
  input  logic                           cl_wb_stb_i,
  input  logic                           cl_wb_we_i,
  input  logic [`MCHAN_ADDR_WIDTH-1:0]   cl_wb_adr_i,
  input  logic [`MCHAN_DATA_WIDTH-1:0]   cl_wb_dat_i,
  input  logic [3:0]                     cl_wb_sel_i,
  output logic [`MCHAN_DATA_WIDTH-1:0]   cl_wb_dat_o,
  output logic                           cl_wb_ack_o,
  // Fabric controller control port
  input  logic                           fc_wb_cyc_i,
  input  logic                           fc_wb_stb_i,
  input  logic                           fc_wb_we_i,
  input  logic [`MCHAN_ADDR_WIDTH-1:0]   fc_wb_adr_i,
  input  logic [`MCHAN_DATA_WIDTH-1:0]   fc_wb_dat_i,
  input  logic [3:0]                     fc_wb_sel_i,
  output logic [`MCHAN_DATA_WIDTH-1:0]   fc_wb_dat_o,
  output logic                           fc_wb_ack_o,
  // TCDM memory port
  output logic                           tcdm_req_o,
  output logic [`MCHAN_ADDR_WIDTH-1:0]   tcdm_add_o,
  output logic                           tcdm_wen_o,
  output logic [`MCHAN_DATA_WIDTH/8-1:0] tcdm_be_o,
  output logic [`MCHAN_DATA_WIDTH-1:0]   tcdm_wdata_o,
  input  logic                           tcdm_gnt_i,
  input  logic                           tcdm_r_valid_i,
  input  logic [`MCHAN_DATA_WIDTH-1:0]   tcdm_r_rdata_i,
  // External memory port
  output logic                           ext_req_o,
  output logic [`MCHAN_ADDR_WIDTH-1:0]   ext_add_o,
  output logic                           ext_wen_o,
  output logic [`MCHAN_DATA_WIDTH/8-1:0] ext_be_o,
  output logic [`MCHAN_DATA_WIDTH-1:0]   ext_wdata_o,
  input  logic                           ext_gnt_i,
  input  logic                           ext_r_valid_i,
  input  logic [`MCHAN_DATA_WIDTH-1:0]   ext_r_rdata_i,
  // Status
  output logic                           term_evt_cl_o,
  output logic                           term_evt_fc_o,
  output logic                           busy_o
);

  logic cl_pending;
  logic fc_pending;
  logic xfer_active;

  // Command links into the transfer unit
  mchan_cmd_if cl_cmd_if ();
  mchan_cmd_if fc_cmd_if ();

  mchan_ctrl_unit cl_ctrl_i (
    .clk_i      ( clk_i         ),
    .arst_n_i   ( arst_n_i      ),
    .wb_cyc_i   ( cl_wb_cyc_i   ),
    .wb_stb_i   ( cl_wb_stb_i   ),
    .wb_we_i    ( cl_wb_we_i    ),
    .wb_adr_i   ( cl_wb_adr_i   ),
    .wb_dat_i   ( cl_wb_dat_i   ),
    .wb_sel_i   ( cl_wb_sel_i   ),
    .wb_dat_o   ( cl_wb_dat_o   ),
    .wb_ack_o   ( cl_wb_ack_o   ),
    .term_evt_o ( term_evt_cl_o ),
    .pending_o  ( cl_pending    ),
    .cmd        ( cl_cmd_if     )
  );

  mchan_ctrl_unit fc_ctrl_i (
    .clk_i      ( clk_i         ),
    .arst_n_i   ( arst_n_i      ),
    .wb_cyc_i   ( fc_wb_cyc_i   ),
    .wb_stb_i   ( fc_wb_stb_i   ),
    .wb_we_i    ( fc_wb_we_i    ),
    .wb_adr_i   ( fc_wb_adr_i   ),
    .wb_dat_i   ( fc_wb_dat_i   ),
    .wb_sel_i   ( fc_wb_sel_i   ),
    .wb_dat_o   ( fc_wb_dat_o   ),
    .wb_ack_o   ( fc_wb_ack_o   ),
    .term_evt_o ( term_evt_fc_o ),
    .pending_o  ( fc_pending    ),
    .cmd        ( fc_cmd_if     )
  );

  mchan_xfer_unit xfer_i (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .cl_cmd         ( cl_cmd_if      ),
    .fc_cmd         ( fc_cmd_if      ),
    .tcdm_req_o     ( tcdm_req_o     ),
    .tcdm_add_o     ( tcdm_add_o     ),
    .tcdm_wen_o     ( tcdm_wen_o     ),
    .tcdm_be_o      ( tcdm_be_o      ),
    .tcdm_wdata_o   ( tcdm_wdata_o   ),
    .tcdm_gnt_i     ( tcdm_gnt_i     ),
    .tcdm_r_valid_i ( tcdm_r_valid_i ),
    .tcdm_r_rdata_i ( tcdm_r_rdata_i ),
    .ext_req_o      ( ext_req_o      ),
    .ext_add_o      ( ext_add_o      ),
    .ext_wen_o      ( ext_wen_o      ),
    .ext_be_o       ( ext_be_o       ),
    .ext_wdata_o    ( ext_wdata_o    ),
    .ext_gnt_i      ( ext_gnt_i      ),
    .ext_r_valid_i  ( ext_r_valid_i  ),
    .ext_r_rdata_i  ( ext_r_rdata_i  ),
    .active_o       ( xfer_active    )
  );

  // Busy while anything is queued or moving
  assign busy_o = cl_pending | fc_pending | xfer_active;

endmodule

`default_nettype wire

//--- tests/dmac_sva.sv
// ****************************************
// Protocol assertions on the DMA top level
// Memory req/gnt, Wishbone ack, term events
// ****************************************

`default_nettype none

module dmac_sva (
  input logic clk_i,
  input logic arst_n_i,
  input logic cl_wb_cyc_i,
  input logic cl_wb_stb_i,
  input logic cl_wb_ack_o,
  input logic fc_wb_cyc_i,
  input logic fc_wb_stb_i,
  input logic fc_wb_ack_o,
  input logic tcdm_req_o,
  input logic tcdm_gnt_i,
  input logic ext_req_o,
  input logic ext_gnt_i,
  input logic term_evt_cl_o,
  input logic term_evt_fc_o
);

  // Failed assertion count, watched by the testbench
  int fail_cnt = 0;

  // req held until gnt on both memory ports
  tcdm_req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tcdm_req_o && !tcdm_gnt_i |=> tcdm_req_o)
    else begin
      $error("TCDM req dropped before gnt");
      fail_cnt++;
    end

  ext_req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ext_req_o && !ext_gnt_i |=> ext_req_o)
    else begin
      $error("External req dropped before gnt");
      fail_cnt++;
    end

  // ack only inside a cycle
  cl_ack_in_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cl_wb_ack_o |-> cl_wb_cyc_i && cl_wb_stb_i)
    else begin
      $error("cl ack without cyc and stb");
      fail_cnt++;
    end

  fc_ack_in_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    fc_wb_ack_o |-> fc_wb_cyc_i && fc_wb_stb_i)
    else begin
      $error("fc ack without cyc and stb");
      fail_cnt++;
    end

  // Termination events are single cycle pulses
  cl_evt_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    term_evt_cl_o |=> !term_evt_cl_o)
    else begin
      $error("cl term event high two cycles");
      fail_cnt++;
    end

  fc_evt_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    term_evt_fc_o |=> !term_evt_fc_o)
    else begin
      $error("fc term event high two cycles");
      fail_cnt++;
    end

endmodule

bind dmac_wrap dmac_sva sva_i (.*);

`default_nettype wire

//--- tests/dmac_tb.sv
// ****************************************
// DMA controller testbench
// Clock, reset, TCDM and external memory models
// Command table, reference copy and checks
// ****************************************

`default_nettype none

`include "mchan_defines.svh"

module dmac_tb;

  localparam int MEM_WORDS = 256;
  localparam int DLY_WORDS = 64;
  localparam int TIMEOUT   = 2000;
  localparam int N_CMDS    = 12;

  // Table columns are port (1 fc), dir (1 TCDM to ext), length in words,
  // source byte address, destination byte address, wait for idle, ack stall expected
  typedef struct packed {
    logic        fc;
    logic        dir;
    logic [15:0] len;
    logic [31:0] src;
    logic [31:0] dst;
    logic        sync;
    logic        stall;
  } cmd_entry_t;

  // DUT signals named as the top-level ports
  logic        clk_i;
  logic        arst_n_i;
  logic        cl_wb_cyc_i, cl_wb_stb_i, cl_wb_we_i;
  logic [31:0] cl_wb_adr_i, cl_wb_dat_i, cl_wb_dat_o;
  logic [3:0]  cl_wb_sel_i;
  logic        cl_wb_ack_o;
  logic        fc_wb_cyc_i, fc_wb_stb_i, fc_wb_we_i;
  logic [31:0] fc_wb_adr_i, fc_wb_dat_i, fc_wb_dat_o;
  logic [3:0]  fc_wb_sel_i;
  logic        fc_wb_ack_o;
  logic        tcdm_req_o, tcdm_wen_o, tcdm_gnt_i, tcdm_r_valid_i;
  logic [31:0] tcdm_add_o, tcdm_wdata_o, tcdm_r_rdata_i;
  logic [3:0]  tcdm_be_o;
  logic        ext_req_o, ext_wen_o, ext_gnt_i, ext_r_valid_i;
  logic [31:0] ext_add_o, ext_wdata_o, ext_r_rdata_i;
  logic [3:0]  ext_be_o;
  logic        term_evt_cl_o, term_evt_fc_o, busy_o;

  // Memories seen by the DUT and their reference copies
  logic [31:0] tcdm_mem [MEM_WORDS];
  logic [31:0] ext_mem  [MEM_WORDS];
  logic [31:0] tcdm_exp [MEM_WORDS];
  logic [31:0] ext_exp  [MEM_WORDS];
  int          gnt_dly  [DLY_WORDS];
  cmd_entry_t  cmd_table [N_CMDS];
  int          access_cnt = 0;
  int          evt_cl;
  int          evt_fc;
  int          issued_cl = 0;
  int          issued_fc = 0;

  dmac_wrap uut (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ****************************************
  // Helpers
  // ****************************************

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] time %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic set_wb(input logic fc, input logic on, input logic we,
                        input logic [31:0] adr, input logic [31:0] dat);
    if (fc) begin
      fc_wb_cyc_i = on;
      fc_wb_stb_i = on;
      fc_wb_we_i  = we;
      fc_wb_adr_i = adr;
      fc_wb_dat_i = dat;
      fc_wb_sel_i = on ? 4'hf : 4'h0;
    end else begin
      cl_wb_cyc_i = on;
      cl_wb_stb_i = on;
      cl_wb_we_i  = we;
      cl_wb_adr_i = adr;
      cl_wb_dat_i = dat;
      cl_wb_sel_i = on ? 4'hf : 4'h0;
    end
  endtask

  // One Wishbone cycle
  // lat counts edges up to the one that sees ack
  task automatic wb_access(input logic fc, input logic we, input logic [31:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat,
                           output int lat);
    logic ack;
    lat = 0;
    @(posedge clk_i);
    #1;
    set_wb(fc, 1'b1, we, adr, wdat);
    do begin
      @(posedge clk_i);
      lat++;
      ack  = fc ? fc_wb_ack_o : cl_wb_ack_o;
      rdat = fc ? fc_wb_dat_o : cl_wb_dat_o;
    end while (!ack && lat < TIMEOUT);
    if (!ack) begin
      abort_run("Wishbone access timed out without ack");
    end
    #1;
    set_wb(fc, 1'b0, 1'b0, '0, '0);
  endtask

  // Program one table entry and update the reference copy
  task automatic issue_cmd(input cmd_entry_t e);
    logic [31:0] rdat;
    int          lat;
    int          s_idx;
    int          d_idx;
    s_idx = e.src[9:2];
    d_idx = e.dst[9:2];
    wb_access(e.fc, 1'b1, 32'(`MCHAN_REG_TCDM_ADDR), e.dir ? e.src : e.dst, rdat, lat);
    wb_access(e.fc, 1'b1, 32'(`MCHAN_REG_EXT_ADDR), e.dir ? e.dst : e.src, rdat, lat);
    // Command word holds length in 15:0 and direction in bit 16
    wb_access(e.fc, 1'b1, 32'(`MCHAN_REG_CMD), {15'h0, e.dir, e.len}, rdat, lat);
    if (e.stall) begin
      if (lat <= 2) begin
        abort_run("Command write was acked while the port queue was full");
      end
    end else begin
      check_value("command write ack latency", lat, 2);
    end
    for (int w = 0; w < int'(e.len); w++) begin
      if (e.dir) begin
        ext_exp[d_idx + w] = tcdm_exp[s_idx + w];
      end else begin
        tcdm_exp[d_idx + w] = ext_exp[s_idx + w];
      end
    end
    if (e.fc) begin
      issued_fc++;
    end else begin
      issued_cl++;
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (busy_o && n < TIMEOUT);
    if (busy_o) begin
      abort_run("DMA stayed busy past the timeout");
    end
    // Termination events trail done by one registered cycle
    repeat (2) @(posedge clk_i);
  endtask

  task automatic load_table();
    // Single copies on cl then fc
    cmd_table[0]  = {1'b0, 1'b0, 16'd8,  32'h000, 32'h000, 1'b1, 1'b0};
    cmd_table[1]  = {1'b1, 1'b1, 16'd5,  32'h100, 32'h100, 1'b1, 1'b0};
    // Both ports back to back
    cmd_table[2]  = {1'b0, 1'b0, 16'd6,  32'h040, 32'h040, 1'b0, 1'b0};
    cmd_table[3]  = {1'b1, 1'b1, 16'd4,  32'h140, 32'h140, 1'b0, 1'b0};
    cmd_table[4]  = {1'b0, 1'b1, 16'd3,  32'h180, 32'h180, 1'b0, 1'b0};
    cmd_table[5]  = {1'b1, 1'b0, 16'd7,  32'h1c0, 32'h1c0, 1'b1, 1'b0};
    // Long copy with two queued behind it
    // The third stalls and overwrites the first queued destination
    cmd_table[6]  = {1'b0, 1'b0, 16'd20, 32'h200, 32'h200, 1'b0, 1'b0};
    cmd_table[7]  = {1'b0, 1'b1, 16'd4,  32'h280, 32'h280, 1'b0, 1'b0};
    cmd_table[8]  = {1'b0, 1'b1, 16'd4,  32'h2a0, 32'h2a0, 1'b0, 1'b0};
    cmd_table[9]  = {1'b0, 1'b1, 16'd4,  32'h2c0, 32'h280, 1'b1, 1'b1};
    // Zero length on each port
    cmd_table[10] = {1'b1, 1'b0, 16'd0,  32'h300, 32'h300, 1'b1, 1'b0};
    cmd_table[11] = {1'b0, 1'b1, 16'd0,  32'h340, 32'h340, 1'b1, 1'b0};
  endtask

  // ****************************************
  // Memory models
  // ****************************************

  initial begin : mem_models
    int   t_idx, e_idx, t_wait, e_wait, t_ptr, e_ptr;
    logic t_rd, e_rd;
    t_wait = 0;
    e_wait = 0;
    t_ptr  = 0;
    e_ptr  = DLY_WORDS / 2;
    tcdm_gnt_i     = 1'b0;
    tcdm_r_valid_i = 1'b0;
    tcdm_r_rdata_i = '0;
    ext_gnt_i      = 1'b0;
    ext_r_valid_i  = 1'b0;
    ext_r_rdata_i  = '0;
    forever begin
      @(posedge clk_i);
      t_rd = 1'b0;
      e_rd = 1'b0;
      // A request seen with gnt at this edge is complete
      if (tcdm_req_o && tcdm_gnt_i) begin
        access_cnt++;
        if (tcdm_add_o[31:10] != 0 || tcdm_add_o[1:0] != 0) begin
          abort_run("TCDM access outside the memory or not word aligned");
        end
        t_idx = tcdm_add_o[9:2];
        if (tcdm_wen_o) begin
          t_rd = 1'b1;
        end else begin
          // Whole words only
          check_value("tcdm_be_o", tcdm_be_o, 4'hf);
          tcdm_mem[t_idx] = tcdm_wdata_o;
        end
      end
      if (ext_req_o && ext_gnt_i) begin
        access_cnt++;
        if (ext_add_o[31:10] != 0 || ext_add_o[1:0] != 0) begin
          abort_run("External access outside the memory or not word aligned");
        end
        e_idx = ext_add_o[9:2];
        if (ext_wen_o) begin
          e_rd = 1'b1;
        end else begin
          check_value("ext_be_o", ext_be_o, 4'hf);
          ext_mem[e_idx] = ext_wdata_o;
        end
      end
      #1;
      // Read data one cycle after its grant
      tcdm_r_valid_i = t_rd;
      ext_r_valid_i  = e_rd;
      if (t_rd) begin
        tcdm_r_rdata_i = tcdm_mem[t_idx];
      end
      if (e_rd) begin
        ext_r_rdata_i = ext_mem[e_idx];
      end
      // Grant after 0 to 3 cycles from the delay table
      tcdm_gnt_i = 1'b0;
      if (tcdm_req_o) begin
        if (t_wait == 0) begin
          tcdm_gnt_i = 1'b1;
          t_wait     = gnt_dly[t_ptr];
          t_ptr      = (t_ptr + 1) % DLY_WORDS;
        end else begin
          t_wait--;
        end
      end
      ext_gnt_i = 1'b0;
      if (ext_req_o) begin
        if (e_wait == 0) begin
          ext_gnt_i = 1'b1;
          e_wait    = gnt_dly[e_ptr];
          e_ptr     = (e_ptr + 1) % DLY_WORDS;
        end else begin
          e_wait--;
        end
      end
    end
  end

  // Event counters and assertion watch
  initial begin : event_monitor
    evt_cl = 0;
    evt_fc = 0;
    forever begin
      @(posedge clk_i);
      if (term_evt_cl_o) begin
        evt_cl++;
      end
      if (term_evt_fc_o) begin
        evt_fc++;
      end
      if (uut.sva_i.fail_cnt != 0) begin
        abort_run("A protocol assertion on the DUT ports failed");
      end
    end
  end

  // ****************************************
  // Main sequence
  // ****************************************

  initial begin : main
    int          acc_before;
    int          lat;
    logic [31:0] rdat;
    void'($urandom(23914));
    arst_n_i = 1'b0;
    set_wb(1'b0, 1'b0, 1'b0, '0, '0);
    set_wb(1'b1, 1'b0, 1'b0, '0, '0);
    for (int i = 0; i < MEM_WORDS; i++) begin
      tcdm_mem[i] = $urandom;
      ext_mem[i]  = $urandom;
      tcdm_exp[i] = tcdm_mem[i];
      ext_exp[i]  = ext_mem[i];
    end
    for (int i = 0; i < DLY_WORDS; i++) begin
      gnt_dly[i] = $urandom_range(3, 0);
    end
    load_table();
    repeat (5) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    for (int i = 0; i < N_CMDS; i++) begin
      acc_before = access_cnt;
      issue_cmd(cmd_table[i]);
      if (cmd_table[i].sync) begin
        wait_idle();
        check_value("term_evt_cl_o count", evt_cl, issued_cl);
        check_value("term_evt_fc_o count", evt_fc, issued_fc);
        for (int w = 0; w < MEM_WORDS; w++) begin
          check_value($sformatf("tcdm word %0d", w), tcdm_mem[w], tcdm_exp[w]);
          check_value($sformatf("ext word %0d", w), ext_mem[w], ext_exp[w]);
        end
        if (cmd_table[i].len == 0) begin
          check_value("memory access count", access_cnt, acc_before);
        end
      end
    end

    // Final status shows idle, nothing pending and completions per port
    check_value("busy_o", busy_o, 0);
    wb_access(1'b0, 1'b0, 32'(`MCHAN_REG_CMD), '0, rdat, lat);
    check_value("cl status word", rdat, 32'(issued_cl) << 8);
    wb_access(1'b1, 1'b0, 32'(`MCHAN_REG_CMD), '0, rdat, lat);
    check_value("fc status word", rdat, 32'(issued_fc) << 8);

    if (uut.sva_i.fail_cnt == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("TESTS FAILED");
      $fatal(1, "protocol assertions failed");
    end
  end

endmodule

`default_nettype wire

//--- dmac.f
+incdir+common
common/mchan_pkg.sv
common/mchan_cmd_if.sv
mchan/mchan_ctrl_unit.sv
mchan/mchan_xfer_unit.sv
design/dmac_wrap.sv
tests/dmac_sva.sv
tests/dmac_tb.sv

//--- Bender.yml
package:
  name: dmac

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mchan_pkg.sv
      - common/mchan_cmd_if.sv
      - mchan/mchan_ctrl_unit.sv
      - mchan/mchan_xfer_unit.sv
      - design/dmac_wrap.sv

  - target: test
    include_dirs:
      - common
    files:
      - tests/dmac_sva.sv
      - tests/dmac_tb.sv
